// ==== Makefile ====
SIM  = obj_dir/Vfetch_tb
SRCS = $(shell grep -v '^+' compile.f) rtl/fetch_consts.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) compile.f
	verilator --binary --timing --assert -f compile.f --top-module fetch_tb \
		-Mdir obj_dir -o Vfetch_tb

run: $(SIM) dv/fetch_trace.txt
	./$(SIM) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_if.sv
rtl/fetch_addr_gen.sv
rtl/iprefetch.sv
rtl/fetch_top.sv
dv/fetch_chk.sv
dv/fetch_tb.sv

// ==== dv/fetch_chk.sv ====
module fetch_chk (
    input logic             clk,
    input logic             reset_n,
    input logic             enable_i,
    input logic             hazard_i,
    input logic             valid_i,
    input fetch_pkg::addr_t pc_i,
    input fetch_pkg::addr_t mem_addr_i
);

    // no delivery while the front end is stalled
    a_stall_no_valid: assert property (@(posedge clk) disable iff (!reset_n)
        !enable_i |-> !valid_i)
        else $error("valid_o high while enable_i is low");

    // instructions sit on halfword boundaries
    a_pc_even: assert property (@(posedge clk) disable iff (!reset_n)
        pc_i[0] == 1'b0)
        else $error("pc_o bit 0 set");

    // a held front end asks memory again for the word in flight
    a_hold_replay: assert property (@(posedge clk) disable iff (!reset_n)
        (!enable_i || hazard_i) |-> mem_addr_i == $past(mem_addr_i))
        else $error("mem_addr_o changed while the front end was held");

endmodule

bind fetch_top fetch_chk u_chk (
    .clk        (clk),
    .reset_n    (reset_n),
    .enable_i   (enable_i),
    .hazard_i   (hazard_i),
    .valid_i    (valid_o),
    .pc_i       (pc_o),
    .mem_addr_i (mem_addr_o)
);

// ==== dv/fetch_tb.sv ====
`include "fetch_consts.svh"

module fetch_tb;

    logic             clk;
    logic             reset_n;
    logic             enable_i;
    logic             hazard_i;
    logic             jump_i;
    fetch_pkg::addr_t jump_target_i;
    fetch_pkg::addr_t mem_addr_o;
    fetch_pkg::word_t mem_data_i;
    logic             valid_o;
    logic             prefetched_o;
    logic             compressed_o;
    fetch_pkg::addr_t pc_o;
    fetch_pkg::word_t instruction_o;

    fetch_pkg::word_t mem [0:255];   // instruction memory model, byte address bits 9:2
    fetch_pkg::addr_t req_q;         // address requested in the previous cycle
    fetch_pkg::addr_t exp_pc [$];    // expected delivery stream
    fetch_pkg::word_t exp_ins [$];
    int               jump_at [$];   // deliveries before each jump
    fetch_pkg::addr_t jump_tgt [$];
    int               win_lo [$];    // random stall windows, by delivery count
    int               win_hi [$];
    logic [15:0]      lfsr;
    int               value_errors;
    int               other_errors;
    int               n_done;
    int               jump_idx;
    logic             jump_pend;

    fetch_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // 16-bit fibonacci, taps 16 14 13 11
    function automatic logic next_bit();
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        return lfsr[0];
    endfunction

    task automatic check_addr(input string name, input fetch_pkg::addr_t exp,
                              input fetch_pkg::addr_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input fetch_pkg::word_t exp,
                              input fetch_pkg::word_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
        end
    endtask

    // outputs while reset is held, before the first fetch
    task automatic check_reset_state();
        check_addr("reset mem_addr", `FETCH_RESET_PC, mem_addr_o);
        check_flag("reset valid", 1'b0, valid_o);
        check_flag("reset prefetched", 1'b0, prefetched_o);
        check_flag("reset compressed", 1'b0, compressed_o);
    endtask

    task automatic load_trace();
        int               fd;
        int               code;
        logic [15:0]      kind;
        logic [8*128-1:0] line;
        fetch_pkg::addr_t a;
        fetch_pkg::word_t d;
        int               lo;
        int               hi;
        fd = $fopen("dv/fetch_trace.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the trace file dv/fetch_trace.txt");
            return;
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "M") begin
                code = $fscanf(fd, "%h %h", a, d);
                mem[a[9:2]] = d;
            end else if (kind == "J") begin
                code = $fscanf(fd, "%d %h", lo, a);
                jump_at.push_back(lo);
                jump_tgt.push_back(a);
            end else if (kind == "S") begin
                code = $fscanf(fd, "%d %d", lo, hi);
                win_lo.push_back(lo);
                win_hi.push_back(hi);
            end else if (kind == "E") begin
                code = $fscanf(fd, "%h %h", a, d);
                exp_pc.push_back(a);
                exp_ins.push_back(d);
            end else begin
                code = $fgets(line, fd);  // comment line
            end
        end
        $fclose(fd);
    endtask

    // inputs for one cycle, applied on the falling edge
    task automatic drive_cycle();
        logic b0;
        logic b1;
        logic in_win;
        in_win = 1'b0;
        foreach (win_lo[i]) begin
            if (n_done >= win_lo[i] && n_done < win_hi[i]) in_win = 1'b1;
        end
        mem_data_i = mem[req_q[9:2]];  // one cycle memory latency
        jump_i     = 1'b0;
        enable_i   = 1'b1;
        hazard_i   = 1'b0;
        if (jump_pend) begin
            jump_i        = 1'b1;
            hazard_i      = 1'b1;          // no delivery in the jump cycle
            jump_target_i = jump_tgt[jump_idx];
            jump_idx++;
            jump_pend = 1'b0;
        end else if (in_win) begin
            b0 = next_bit();
            b1 = next_bit();
            enable_i = !(b0 && b1);        // stall about one cycle in four
            b0 = next_bit();
            b1 = next_bit();
            hazard_i = b0 && b1;
        end
    endtask

    task automatic sample_cycle();
        logic  exp_c;
        string name;
        if (!enable_i || hazard_i) check_flag("gated cycle valid", 1'b0, valid_o);
        if (valid_o) begin
            name  = $sformatf("delivery %0d", n_done);
            exp_c = (exp_ins[n_done][1:0] != 2'b11);  // RV32C length rule
            check_addr({name, " pc"}, exp_pc[n_done], pc_o);
            check_word({name, " instruction"}, exp_ins[n_done], instruction_o);
            check_flag({name, " compressed"}, exp_c, compressed_o);
            check_flag({name, " prefetched"}, exp_c && exp_pc[n_done][1], prefetched_o);
            n_done++;
            if (jump_idx < jump_at.size() && n_done == jump_at[jump_idx]) jump_pend = 1'b1;
        end
    endtask

    initial begin
        int idle;
        reset_n       = 1'b0;
        enable_i      = 1'b0;
        hazard_i      = 1'b0;
        jump_i        = 1'b0;
        jump_target_i = '0;
        mem_data_i    = '0;
        req_q         = '0;
        lfsr          = 16'd96;
        value_errors  = 0;
        other_errors  = 0;
        n_done        = 0;
        jump_idx      = 0;
        jump_pend     = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fetch_pkg::word_t'(i) * 32'h9E37_79B9;  // filler, unique per word
        end
        load_trace();
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        reset_n = 1'b1;
        idle = 0;
        while (n_done < exp_pc.size() && other_errors == 0) begin
            drive_cycle();
            #1;
            req_q = mem_addr_o;
            sample_cycle();
            idle = valid_o ? 0 : idle + 1;
            if (idle > 50) begin
                other_errors++;
                $display("timeout: no instruction delivered for 50 cycles after %0d", n_done);
            end
            @(negedge clk);
        end
        $display("value errors %0d, other errors %0d, delivered %0d of %0d",
                 value_errors, other_errors, n_done, exp_pc.size());
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== dv/fetch_trace.txt ====
# M byte_addr word | J deliveries_before_jump target | S first_delivery end_delivery (random stalls)
# E pc instruction, in delivery order, 16-bit instructions zero extended
M 00000000 00100093
M 00000004 00200113
M 00000008 00b34505
M 0000000c 45850031
M 00000010 46094605
M 00000014 00300193
M 00000018 00400213
M 0000001c 00500293
M 00000040 00600313
M 00000044 00700393
M 00000048 00800413
M 00000080 04930000
M 00000084 46850090
M 00000088 00a00513
M 0000008c 00b00593
J 10 00000040
J 13 00000082
S 3 9
S 12 17
E 00000000 00100093
E 00000004 00200113
E 00000008 00004505
E 0000000a 003100b3
E 0000000e 00004585
E 00000010 00004605
E 00000012 00004609
E 00000014 00300193
E 00000018 00400213
E 0000001c 00500293
E 00000040 00600313
E 00000044 00700393
E 00000048 00800413
E 00000082 00900493
E 00000086 00004685
E 00000088 00a00513
E 0000008c 00b00593

// ==== rtl/fetch_addr_gen.sv ====
`include "fetch_consts.svh"

module fetch_addr_gen (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             enable_i,       // run level, low = stall
    input  logic             hazard_i,       // consumer back-pressure
    input  logic             jump_i,         // one-cycle redirect pulse
    input  fetch_pkg::addr_t jump_target_i,  // halfword aligned target
    input  logic             prefetched_i,   // next instruction already buffered
    output fetch_pkg::addr_t mem_addr_o,     // word address to memory
    input  fetch_pkg::word_t mem_data_i,     // word requested last cycle
    output logic             valid_o,        // instruction on the outputs is real
    fetch_if.gen             fi
);

    fetch_pkg::addr_t fetch_addr_r;  // next request, keeps bit 1 of a jump target
    fetch_pkg::tag_t  tag_r;         // live redirect tag
    fetch_pkg::addr_t word_pc_r;     // address of the word now arriving
    fetch_pkg::tag_t  word_tag_r;    // tag of the word now arriving

    logic             hold;          // stall or hazard, nothing moves
    logic             current;       // arriving word belongs to the live tag
    logic             split;         // 32-bit entry instruction needs the next word
    logic             advance;       // step the fetch address this cycle
    fetch_pkg::addr_t next_addr;     // following word boundary
    fetch_pkg::addr_t req_addr;      // address presented to memory

    assign hold    = !enable_i || hazard_i;
    assign current = (word_tag_r == tag_r);  // words requested before a jump are stale

    // only the entry word of a redirect can have bit 1 set in its address
    assign split = word_pc_r[1] && (mem_data_i[17:16] == 2'b11);

    // a buffered upper-half instruction leaves the arriving word for next cycle
    assign advance = !hold && !(prefetched_i && current);

    assign next_addr = {fetch_addr_r[`FETCH_ADDR_W-1:2], 2'b00} + fetch_pkg::addr_t'(4);

    // while held, ask again for the word in flight so it shows up unchanged
    assign req_addr   = hold ? word_pc_r : fetch_addr_r;
    assign mem_addr_o = {req_addr[`FETCH_ADDR_W-1:2], 2'b00};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_addr_r <= `FETCH_RESET_PC;
            tag_r        <= '0;
            word_pc_r    <= `FETCH_RESET_PC;
            word_tag_r   <= '1;                   // differs from tag_r, first word is dropped
        end else if (enable_i) begin
            if (!hazard_i) begin
                word_pc_r  <= fetch_addr_r;       // travels with the word requested now
                word_tag_r <= tag_r;
            end
            if (jump_i) begin
                fetch_addr_r <= jump_target_i;    // redirect wins over any hold
                tag_r        <= tag_r + 1'b1;     // marks everything in flight stale
            end else if (advance) begin
                fetch_addr_r <= next_addr;
            end
        end
    end

    // valid is lost after reset and after a jump until a current word arrives
    assign valid_o = !hold && current && !split;

    assign fi.word     = mem_data_i;  // memory answers in one cycle
    assign fi.word_pc  = word_pc_r;
    assign fi.word_tag = word_tag_r;
    assign fi.enable   = enable_i;
    assign fi.hazard   = hazard_i;

endmodule

// ==== rtl/fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// byte address width of the fetch path
`define FETCH_ADDR_W 32

// instruction memory word width
`define FETCH_DATA_W 32

// redirect tag width, wraps after eight jumps
`define FETCH_TAG_W 3

// first fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

// ==== rtl/fetch_if.sv ====
interface fetch_if;

    fetch_pkg::word_t word;      // memory word, one cycle after its request
    fetch_pkg::addr_t word_pc;   // address the word was requested with
    fetch_pkg::tag_t  word_tag;  // redirect tag live at request time
    logic             enable;    // front-end run level, low = stall
    logic             hazard;    // consumer cannot take an instruction

    // the address generator owns every signal
    modport gen (
        output word,
        output word_pc,
        output word_tag,
        output enable,
        output hazard
    );

    // the prefetcher only listens
    modport pf (
        input  word,
        input  word_pc,
        input  word_tag,
        input  enable,
        input  hazard
    );

endinterface

// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

`include "fetch_consts.svh"

    // byte address, halfword aligned for instructions
    typedef logic [`FETCH_ADDR_W-1:0] addr_t;

    // memory word, or one realigned instruction
    typedef logic [`FETCH_DATA_W-1:0] word_t;

    // one 16-bit instruction parcel, lower or upper half of a word
    typedef logic [15:0] half_t;

    // redirect tag, bumped on every jump
    typedef logic [`FETCH_TAG_W-1:0] tag_t;

endpackage

// ==== rtl/fetch_top.sv ====
module fetch_top (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             enable_i,       // front-end run level
    input  logic             hazard_i,       // consumer back-pressure
    input  logic             jump_i,         // redirect pulse
    input  fetch_pkg::addr_t jump_target_i,  // redirect target
    output fetch_pkg::addr_t mem_addr_o,     // instruction memory address
    input  fetch_pkg::word_t mem_data_i,     // instruction memory data, one cycle later
    output logic             valid_o,        // delivered instruction strobe
    output logic             prefetched_o,   // delivered from the word buffer
    output logic             compressed_o,   // 16-bit instruction
    output fetch_pkg::addr_t pc_o,           // instruction pc
    output fetch_pkg::word_t instruction_o   // realigned instruction
);

    fetch_if fi ();  // generator to prefetcher

    fetch_addr_gen u_gen (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .hazard_i      (hazard_i),
        .jump_i        (jump_i),
        .jump_target_i (jump_target_i),
        .prefetched_i  (prefetched_o),  // buffered instruction holds the fetch address
        .mem_addr_o    (mem_addr_o),
        .mem_data_i    (mem_data_i),
        .valid_o       (valid_o),
        .fi            (fi.gen)
    );

    iprefetch u_pf (
        .clk           (clk),
        .reset_n       (reset_n),
        .fi            (fi.pf),
        .prefetched_o  (prefetched_o),
        .compressed_o  (compressed_o),
        .pc_o          (pc_o),
        .instruction_o (instruction_o)
    );

endmodule

// ==== rtl/iprefetch.sv ====
module iprefetch (
    input  logic             clk,
    input  logic             reset_n,
    fetch_if.pf              fi,
    output logic             prefetched_o,   // upper-half compressed, next one is buffered
    output logic             compressed_o,   // instruction_o is a 16-bit one
    output fetch_pkg::addr_t pc_o,           // pc of instruction_o
    output fetch_pkg::word_t instruction_o   // realigned instruction
);

    fetch_pkg::tag_t  tag_r;        // tag of the last word taken
    fetch_pkg::addr_t pc_r;         // pc of the next instruction
    fetch_pkg::word_t buf_r;        // previous word, source of spliced halves
    logic             pf_r;         // current pc sits in buf_r, not in fi.word
    logic             live_r;       // a word has been taken since reset

    logic             step;         // take the instruction, move on
    logic             new_tag;      // first word after a redirect
    fetch_pkg::addr_t pc;
    logic             misaligned;   // pc in the upper half of its word
    logic             entry;        // redirect landed in an upper half
    logic             use_buf;      // instruction comes whole from buf_r
    fetch_pkg::half_t lo_half;      // first parcel of the instruction
    fetch_pkg::half_t hi_half;      // second parcel, only for 32-bit
    fetch_pkg::word_t instruction;
    logic             compressed;
    logic             split;        // 32-bit entry instruction waits for the next word
    fetch_pkg::addr_t pc_add;

    assign step    = fi.enable && !fi.hazard;  // same condition as the generator
    assign new_tag = (fi.word_tag != tag_r);

    // after a redirect the pc restarts from the address that came with the word
    assign pc         = new_tag ? fi.word_pc : pc_r;
    assign misaligned = pc[1];
    assign entry      = new_tag && misaligned;
    assign use_buf    = pf_r && !new_tag;

    // parcel selection
    // in steady misaligned mode the arriving word is one ahead of the pc
    always_comb begin
        if (entry) begin
            lo_half = fi.word[31:16];  // arriving word still holds the pc
            hi_half = '0;              // second parcel not fetched yet
        end else if (misaligned) begin
            lo_half = buf_r[31:16];    // splice: upper half of the previous word
            hi_half = fi.word[15:0];   // and lower half of the new one
        end else if (use_buf) begin
            lo_half = buf_r[15:0];     // word already consumed from memory
            hi_half = buf_r[31:16];
        end else begin
            lo_half = fi.word[15:0];   // plain aligned fetch
            hi_half = fi.word[31:16];
        end
    end

    assign compressed = (lo_half[1:0] != 2'b11);  // RV32C: 2'b11 means 32-bit
    assign split      = entry && !compressed;

    // upper parcel cleared for 16-bit instructions
    assign instruction = compressed ? {fetch_pkg::half_t'('0), lo_half} : {hi_half, lo_half};

    assign pc_add = compressed ? fetch_pkg::addr_t'(2) : fetch_pkg::addr_t'(4);

    // compressed in the upper half while the next word is arriving
    // the next instruction is then the arriving word, so the generator waits
    assign prefetched_o  = misaligned && compressed && !new_tag;
    assign compressed_o  = compressed && live_r;
    assign pc_o          = pc;
    assign instruction_o = instruction;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_r  <= '0;
            pc_r   <= '0;
            pf_r   <= 1'b0;
            live_r <= 1'b0;
        end else if (step) begin
            tag_r  <= fi.word_tag;
            pc_r   <= split ? pc : pc + pc_add;  // split keeps the pc for one more cycle
            pf_r   <= prefetched_o;
            live_r <= 1'b1;
        end
    end

    // hazard freezes the buffer, and so does a cycle that reads from it
    always_ff @(posedge clk) begin
        if (step && !use_buf) begin
            buf_r <= fi.word;
        end
    end

endmodule
